// ==== filelist.f ====
logic/colmix_pkg.sv
logic/layer_prio_mixer.sv
logic/palette_ram.sv
logic/color_output.sv
logic/colmix_top.sv
verif/colmix_tb.sv

// ==== logic/colmix_pkg.sv ====
/*
    shared types of the colour mixer
    pixel code low nibble is the colour index, 15 means transparent
    palette address is {layer, code}, 12 bits wide
    palette words hold br, r, g, b from the top, 4 bits each
*/
package colmix_pkg;

    // source layer of a queue entry
    typedef logic [2:0] layer_id_t;

    localparam layer_id_t lyr_obj  = 3'd0;
    localparam layer_id_t lyr_scr1 = 3'd1;
    localparam layer_id_t lyr_scr2 = 3'd2;
    localparam layer_id_t lyr_scr3 = 3'd3;
    localparam layer_id_t lyr_star = 3'd4;

    // one entry of the priority queue
    typedef struct packed {
        logic [1:0] group;
        layer_id_t  layer;
        logic [8:0] code;
    } layer_pxl_t;

    // shifted into the queue tail, palette address bff
    localparam layer_pxl_t blank_pxl = '{group: 2'd3, layer: 3'd5, code: 9'h1ff};

    typedef struct packed {
        logic [3:0] br;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pal_entry_t;

    // layer control, enable masks and per-group priority masks
    typedef struct packed {
        logic [15:0] layer_ctrl;
        logic [7:0]  mask0;
        logic [7:0]  mask1;
        logic [7:0]  mask2;
        logic [7:0]  mask3;
        logic [7:0]  mask4;
        logic [15:0] prio0;
        logic [15:0] prio1;
        logic [15:0] prio2;
        logic [15:0] prio3;
        logic [3:0]  gfx_en;
    } mix_cfg_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

endpackage

// ==== logic/colmix_top.sv ====
/*
    colour mixer top level
    pxl_cen strobes at least 7 clk apart
    rgb lags the layer inputs by two strobes
    cfg should only change during blanking
*/
`timescale 1ns/100ps

module colmix_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    vb,
    input  logic                    hb,
    input  colmix_pkg::mix_cfg_t    cfg,
    input  logic [10:0]             scr1_pxl,
    input  logic [10:0]             scr2_pxl,
    input  logic [10:0]             scr3_pxl,
    input  logic [8:0]              obj_pxl,
    input  logic [8:0]              star0_pxl,
    input  logic [8:0]              star1_pxl,
    input  logic                    pal_we,
    input  logic [11:0]             pal_wr_addr,
    input  colmix_pkg::pal_entry_t  pal_wr_data,
    output colmix_pkg::rgb_t        rgb,
    output logic                    lvbl,
    output logic                    lhbl
);

    logic [11:0]            pal_addr;
    colmix_pkg::pal_entry_t pal_rd;

    // priority resolution, one strobe
    layer_prio_mixer i_layer_prio_mixer (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .cfg       (cfg),
        .obj_pxl   (obj_pxl),
        .star0_pxl (star0_pxl),
        .star1_pxl (star1_pxl),
        .scr1_pxl  (scr1_pxl),
        .scr2_pxl  (scr2_pxl),
        .scr3_pxl  (scr3_pxl),
        .pal_addr  (pal_addr)
    );

    palette_ram i_palette_ram (
        .clk     (clk),
        .we      (pal_we),
        .wr_addr (pal_wr_addr),
        .wr_data (pal_wr_data),
        .rd_addr (pal_addr),
        .rd_data (pal_rd)
    );

    // brightness and blanking, second strobe
    color_output i_color_output (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .vb      (vb),
        .hb      (hb),
        .pal_rd  (pal_rd),
        .rgb     (rgb),
        .lvbl    (lvbl),
        .lhbl    (lhbl)
    );

endmodule

// ==== logic/color_output.sv ====
/*
    brightness scaling and blanking of the rgb outputs
    pal_rd must settle at least 2 clk before the next pxl_cen
    blanking sampled at strobe k applies to rgb at strobe k+2
    outputs stay blanked for two strobes after reset
*/
`timescale 1ns/100ps

module color_output (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pxl_cen,
    input  logic                    vb,
    input  logic                    hb,
    input  colmix_pkg::pal_entry_t  pal_rd,
    output colmix_pkg::rgb_t        rgb,
    output logic                    lvbl,
    output logic                    lhbl
);

    logic [3:0] inv_br;
    logic [7:0] m_r;
    logic [7:0] m_g;
    logic [7:0] m_b;
    logic [3:0] c_r;
    logic [3:0] c_g;
    logic [3:0] c_b;
    logic [1:0] vb_sh;
    logic [1:0] hb_sh;

    // c*17 - m/2 - m/4, full c*17 at br = 15
    function automatic logic [7:0] scale(input logic [3:0] c, input logic [7:0] m);
        return {c, c} - (m >> 1) - (m >> 2);
    endfunction

    assign inv_br = 4'hf - pal_rd.br;

    // multiplier stage runs every clk
    always_ff @(posedge clk) begin
        m_r <= {4'd0, pal_rd.r} * {4'd0, inv_br};
        m_g <= {4'd0, pal_rd.g} * {4'd0, inv_br};
        m_b <= {4'd0, pal_rd.b} * {4'd0, inv_br};
        c_r <= pal_rd.r;
        c_g <= pal_rd.g;
        c_b <= pal_rd.b;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // start out blanked
            vb_sh <= 2'b11;
            hb_sh <= 2'b11;
            lvbl  <= 1'b0;
            lhbl  <= 1'b0;
            rgb   <= '0;
        end else if (pxl_cen) begin
            // two-strobe blanking delay
            vb_sh <= {vb_sh[0], vb};
            hb_sh <= {hb_sh[0], hb};
            lvbl  <= ~vb_sh[1];
            lhbl  <= ~hb_sh[1];
            if (vb_sh[1] || hb_sh[1]) begin
                rgb <= '0;
            end else begin
                rgb.red   <= scale(c_r, m_r);
                rgb.green <= scale(c_g, m_g);
                rgb.blue  <= scale(c_b, m_b);
            end
        end
    end

    blank_black_a: assert property (
        @(posedge clk) disable iff (rst)
        (!lvbl || !lhbl) |-> (rgb == '0)
    ) else $error("rgb not black during blanking");

endmodule

// ==== logic/layer_prio_mixer.sv ====
/*
    layer masking and priority resolution
    pxl_cen strobes must be at least 7 clk apart, the queue needs
    5 shift cycles between strobes
    pal_addr is the winner of the pixel latched one strobe earlier
    cfg must stay stable within a line
*/
`timescale 1ns/100ps

module layer_prio_mixer (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  colmix_pkg::mix_cfg_t  cfg,
    input  logic [8:0]            obj_pxl,
    input  logic [8:0]            star0_pxl,
    input  logic [8:0]            star1_pxl,
    input  logic [10:0]           scr1_pxl,
    input  logic [10:0]           scr2_pxl,
    input  logic [10:0]           scr3_pxl,
    output logic [11:0]           pal_addr
);

    logic [4:0]  lyr_en;
    logic [8:0]  obj_m;
    logic [8:0]  star0_m;
    logic [8:0]  star1_m;
    logic [10:0] scr1_m;
    logic [10:0] scr2_m;
    logic [10:0] scr3_m;

    colmix_pkg::layer_pxl_t       star0_ent;
    colmix_pkg::layer_pxl_t       star1_ent;
    colmix_pkg::layer_pxl_t [3:0] slot_ent;
    colmix_pkg::layer_pxl_t [4:0] queue;
    colmix_pkg::layer_pxl_t       cur;
    colmix_pkg::layer_pxl_t       cand;

    logic has_prio;
    logic prio_flag;
    logic take;

    // picks object or one scroll layer for a queue slot
    function automatic colmix_pkg::layer_pxl_t slot_mux(
        input logic [1:0]  sel,
        input logic [8:0]  obj,
        input logic [10:0] s1,
        input logic [10:0] s2,
        input logic [10:0] s3
    );
        colmix_pkg::layer_pxl_t ent;
        case (sel)
            2'd0: ent = '{group: 2'd0, layer: colmix_pkg::lyr_obj, code: obj};
            2'd1: ent = '{group: s1[10:9], layer: colmix_pkg::lyr_scr1, code: s1[8:0]};
            2'd2: ent = '{group: s2[10:9], layer: colmix_pkg::lyr_scr2, code: s2[8:0]};
            default: ent = '{group: s3[10:9], layer: colmix_pkg::lyr_scr3, code: s3[8:0]};
        endcase
        return ent;
    endfunction

    // layer enables, only bits 5:0 of the masks count
    assign lyr_en[0] = |(cfg.mask0[5:0] & cfg.layer_ctrl[5:0]);
    assign lyr_en[1] = |(cfg.mask1[5:0] & cfg.layer_ctrl[5:0]);
    assign lyr_en[2] = |(cfg.mask2[5:0] & cfg.layer_ctrl[5:0]);
    assign lyr_en[3] = |(cfg.mask3[5:0] & cfg.layer_ctrl[5:0]);
    assign lyr_en[4] = |(cfg.mask4[5:0] & cfg.layer_ctrl[5:0]);

    // disabled layers turn transparent
    // objects only follow gfx_en[3]
    assign obj_m   = {obj_pxl[8:4], obj_pxl[3:0] | {4{~cfg.gfx_en[3]}}};
    assign scr1_m  = {scr1_pxl[10:4], scr1_pxl[3:0] | {4{~(lyr_en[0] & cfg.gfx_en[0])}}};
    assign scr2_m  = {scr2_pxl[10:4], scr2_pxl[3:0] | {4{~(lyr_en[1] & cfg.gfx_en[1])}}};
    assign scr3_m  = {scr3_pxl[10:4], scr3_pxl[3:0] | {4{~(lyr_en[2] & cfg.gfx_en[2])}}};
    assign star0_m = {star0_pxl[8:4], star0_pxl[3:0] | {4{~lyr_en[3]}}};
    assign star1_m = {star1_pxl[8:4], star1_pxl[3:0] | {4{~lyr_en[4]}}};

    assign star0_ent = '{group: 2'd0, layer: colmix_pkg::lyr_star, code: star0_m};
    assign star1_ent = '{group: 2'd0, layer: colmix_pkg::lyr_star, code: star1_m};

    // slot order follows layer_ctrl fields from 7:6 up to 13:12
    assign slot_ent[0] = slot_mux(cfg.layer_ctrl[7:6], obj_m, scr1_m, scr2_m, scr3_m);
    assign slot_ent[1] = slot_mux(cfg.layer_ctrl[9:8], obj_m, scr1_m, scr2_m, scr3_m);
    assign slot_ent[2] = slot_mux(cfg.layer_ctrl[11:10], obj_m, scr1_m, scr2_m, scr3_m);
    assign slot_ent[3] = slot_mux(cfg.layer_ctrl[13:12], obj_m, scr1_m, scr2_m, scr3_m);

    assign cand = queue[0];

    // priority bit of the current entry's group at its colour
    always_comb begin
        case (cur.group)
            2'd0: has_prio = cfg.prio0[cur.code[3:0]];
            2'd1: has_prio = cfg.prio1[cur.code[3:0]];
            2'd2: has_prio = cfg.prio2[cur.code[3:0]];
            default: has_prio = cfg.prio3[cur.code[3:0]];
        endcase
    end

    // a transparent current entry always gives way
    // an object behind a prioritised pixel is held off
    assign take = (cur.code[3:0] == 4'hf) ||
                  ((cand.code[3:0] != 4'hf) &&
                   !((cand.layer == colmix_pkg::lyr_obj) && prio_flag && has_prio));

    // star1 starts as the current entry, the rest queue up behind it
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pal_addr <= {cur.layer, cur.code};
            cur      <= star1_ent;
            queue    <= {slot_ent[3], slot_ent[2], slot_ent[1], slot_ent[0], star0_ent};
        end else begin
            if (take) begin
                cur <= cand;
            end
            queue <= {colmix_pkg::blank_pxl, queue[4:1]};
        end
    end

    // set only after a non-star entry was accepted
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prio_flag <= 1'b0;
        end else if (pxl_cen) begin
            prio_flag <= 1'b0;
        end else if (take) begin
            prio_flag <= (cand.layer != colmix_pkg::lyr_star);
        end else begin
            prio_flag <= 1'b0;
        end
    end

    // queue drain plus palette read and multiply need 7 cycles per pixel
    strobe_spacing_a: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen [*6]
    ) else $error("pxl_cen strobes closer than 7 clk cycles");

endmodule

// ==== logic/palette_ram.sv ====
/*
    4096 x 16 palette memory, one write and one read port
    read data is registered, a read at the write edge returns old data
    contents are not cleared by reset
*/
`timescale 1ns/100ps

module palette_ram (
    input  logic                    clk,
    input  logic                    we,
    input  logic [11:0]             wr_addr,
    input  colmix_pkg::pal_entry_t  wr_data,
    input  logic [11:0]             rd_addr,
    output colmix_pkg::pal_entry_t  rd_data
);

    colmix_pkg::pal_entry_t mem [0:4095];

    // cpu side write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // video side read, one clk latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    wr_addr_known_a: assert property (
        @(posedge clk) we |-> !$isunknown(wr_addr)
    ) else $error("palette write with unknown address");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the colour mixer testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module colmix_tb -f filelist.f -o colmix_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/colmix_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// ==== verif/colmix_tb.sv ====
/*
    random testbench for the colour mixer
    pxl_cen fires every 8 clk, layer codes and cfg change only before a strobe
    palette is filled once before the first pixel and then held
    rgb is expected two strobes after the pixel that produced it
*/
`timescale 1ns/100ps

module colmix_tb;

    localparam int n_pixels    = 600;
    localparam int cycle_limit = 4096 + n_pixels * 8 + 200;

    logic                   clk;
    logic                   rst;
    logic                   pxl_cen;
    logic                   vb;
    logic                   hb;
    colmix_pkg::mix_cfg_t   cfg;
    logic [10:0]            scr1_pxl;
    logic [10:0]            scr2_pxl;
    logic [10:0]            scr3_pxl;
    logic [8:0]             obj_pxl;
    logic [8:0]             star0_pxl;
    logic [8:0]             star1_pxl;
    logic                   pal_we;
    logic [11:0]            pal_wr_addr;
    colmix_pkg::pal_entry_t pal_wr_data;
    colmix_pkg::rgb_t       rgb;
    logic                   lvbl;
    logic                   lhbl;

    integer seed = 32'hcec3_72c7;
    int     errors;
    int     strobe_no;
    int     cycles;
    int     run_left;
    logic   vb_run;
    logic   hb_run;

    // mirror of the palette and expected outputs in flight
    colmix_pkg::pal_entry_t pal_model [0:4095];
    colmix_pkg::rgb_t       exp_rgb [$];
    logic [1:0]             exp_vis [$];

    colmix_top i_colmix_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // hang guard
    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: test did not finish within %0d clk cycles, the run hung", cycles);
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

    function automatic logic [10:0] rand_pixel();
        logic [10:0] p;
        p = 11'($random(seed));
        // roughly a third transparent
        if ($unsigned($random(seed)) % 3 == 0) begin
            p[3:0] = 4'hf;
        end
        return p;
    endfunction

    // every field random, slot selects in layer_ctrl included
    function automatic colmix_pkg::mix_cfg_t rand_cfg();
        logic [127:0] r;
        r = {$random(seed), $random(seed), $random(seed), $random(seed)};
        return r[$bits(colmix_pkg::mix_cfg_t)-1:0];
    endfunction

    // 0 = object, 1..3 = scroll layers, group from scroll bits 10:9
    function automatic colmix_pkg::layer_pxl_t pick_slot(input logic [1:0] sel,
            input logic [8:0] obj, input logic [10:0] s1, input logic [10:0] s2,
            input logic [10:0] s3);
        colmix_pkg::layer_pxl_t e;
        if (sel == 2'd0) e = '{group: 2'd0, layer: colmix_pkg::lyr_obj, code: obj};
        else if (sel == 2'd1) e = '{group: s1[10:9], layer: colmix_pkg::lyr_scr1, code: s1[8:0]};
        else if (sel == 2'd2) e = '{group: s2[10:9], layer: colmix_pkg::lyr_scr2, code: s2[8:0]};
        else e = '{group: s3[10:9], layer: colmix_pkg::lyr_scr3, code: s3[8:0]};
        return e;
    endfunction

    // winning palette address of one pixel stack
    function automatic logic [11:0] resolve_addr(input colmix_pkg::mix_cfg_t c,
            input logic [8:0] obj, input logic [8:0] star0, input logic [8:0] star1,
            input logic [10:0] s1, input logic [10:0] s2, input logic [10:0] s3);
        colmix_pkg::layer_pxl_t q [0:7];
        colmix_pkg::layer_pxl_t cur;
        colmix_pkg::layer_pxl_t cand;
        logic [15:0]            prio_words [0:3];
        logic                   flag;
        logic                   hold;
        // disabled layers go transparent, objects only see gfx_en[3]
        if (!(|(c.mask0[5:0] & c.layer_ctrl[5:0])) || !c.gfx_en[0]) s1[3:0] = 4'hf;
        if (!(|(c.mask1[5:0] & c.layer_ctrl[5:0])) || !c.gfx_en[1]) s2[3:0] = 4'hf;
        if (!(|(c.mask2[5:0] & c.layer_ctrl[5:0])) || !c.gfx_en[2]) s3[3:0] = 4'hf;
        if (!(|(c.mask3[5:0] & c.layer_ctrl[5:0]))) star0[3:0] = 4'hf;
        if (!(|(c.mask4[5:0] & c.layer_ctrl[5:0]))) star1[3:0] = 4'hf;
        if (!c.gfx_en[3]) obj[3:0] = 4'hf;
        prio_words[0] = c.prio0;
        prio_words[1] = c.prio1;
        prio_words[2] = c.prio2;
        prio_words[3] = c.prio3;
        cur  = '{group: 2'd0, layer: colmix_pkg::lyr_star, code: star1};
        q[0] = '{group: 2'd0, layer: colmix_pkg::lyr_star, code: star0};
        q[1] = pick_slot(c.layer_ctrl[7:6], obj, s1, s2, s3);
        q[2] = pick_slot(c.layer_ctrl[9:8], obj, s1, s2, s3);
        q[3] = pick_slot(c.layer_ctrl[11:10], obj, s1, s2, s3);
        q[4] = pick_slot(c.layer_ctrl[13:12], obj, s1, s2, s3);
        for (int i = 5; i < 8; i++) q[3'(i)] = colmix_pkg::blank_pxl;
        flag = 1'b0;
        // one candidate per clk between strobes
        for (int i = 0; i < 7; i++) begin
            cand = q[3'(i)];
            hold = (cand.layer == colmix_pkg::lyr_obj) && flag &&
                   prio_words[cur.group][cur.code[3:0]];
            if ((cur.code[3:0] == 4'hf) || ((cand.code[3:0] != 4'hf) && !hold)) begin
                cur  = cand;
                flag = (cand.layer != colmix_pkg::lyr_star);
            end else begin
                flag = 1'b0;
            end
        end
        return {cur.layer, cur.code};
    endfunction

    // c*17 minus half and quarter of c*(15-br)
    function automatic logic [7:0] bright(input logic [3:0] c, input logic [3:0] br);
        int m;
        m = int'(c) * (15 - int'(br));
        return 8'(int'(c) * 17 - m / 2 - m / 4);
    endfunction

    task automatic push_expected();
        colmix_pkg::pal_entry_t pe;
        colmix_pkg::rgb_t       e;
        pe = pal_model[resolve_addr(cfg, obj_pxl, star0_pxl, star1_pxl,
                                    scr1_pxl, scr2_pxl, scr3_pxl)];
        e.red   = bright(pe.r, pe.br);
        e.green = bright(pe.g, pe.br);
        e.blue  = bright(pe.b, pe.br);
        if (vb || hb) e = '0;
        exp_rgb.push_back(e);
        exp_vis.push_back({~vb, ~hb});
    endtask

    task automatic check_rgb(input colmix_pkg::rgb_t got, input colmix_pkg::rgb_t want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] rgb got %h expected %h at strobe %0d", got, want, strobe_no);
            $display("=== FAIL ===");
            $fatal(1, "rgb mismatch");
        end
    endtask

    // bits are {lvbl, lhbl}
    task automatic check_blank(input logic [1:0] got, input logic [1:0] want);
        if (got !== want) begin
            errors++;
            $display("[FAIL] lvbl/lhbl got %h expected %h at strobe %0d", got, want, strobe_no);
            $display("=== FAIL ===");
            $fatal(1, "blanking mismatch");
        end
    endtask

    initial begin
        colmix_pkg::rgb_t want_rgb;
        logic [1:0]       want_vis;
        rst         = 1'b1;
        pxl_cen     = 1'b0;
        vb          = 1'b0;
        hb          = 1'b0;
        cfg         = '0;
        scr1_pxl    = '0;
        scr2_pxl    = '0;
        scr3_pxl    = '0;
        obj_pxl     = '0;
        star0_pxl   = '0;
        star1_pxl   = '0;
        pal_we      = 1'b0;
        pal_wr_addr = '0;
        pal_wr_data = '0;
        errors      = 0;
        strobe_no   = 0;
        run_left    = 0;
        vb_run      = 1'b0;
        hb_run      = 1'b0;
        repeat (2) @(negedge clk);
        check_rgb(rgb, '0);
        check_blank({lvbl, lhbl}, 2'b00);
        rst = 1'b0;

        // palette fill, one word per clk
        pal_we = 1'b1;
        for (int a = 0; a < 4096; a++) begin
            pal_wr_addr = 12'(a);
            pal_wr_data = 16'($random(seed));
            pal_model[12'(a)] = pal_wr_data;
            @(negedge clk);
        end
        pal_we = 1'b0;
        check_rgb(rgb, '0);
        check_blank({lvbl, lhbl}, 2'b00);

        // still blanked from reset for two strobes
        repeat (2) begin
            exp_rgb.push_back('0);
            exp_vis.push_back(2'b00);
        end
        cfg = rand_cfg();
        for (int n = 0; n < n_pixels; n++) begin
            if (n > 0 && n % 50 == 0) cfg = rand_cfg();
            if (run_left == 0) begin
                run_left = 2 + int'($unsigned($random(seed)) % 8);
                vb_run   = ($random(seed) & 7) == 0;
                hb_run   = ($random(seed) & 3) == 0;
            end
            run_left--;
            // vertical blank around each cfg change
            vb        = vb_run || (n % 50 == 49) || (n > 0 && n % 50 == 0);
            hb        = hb_run;
            scr1_pxl  = rand_pixel();
            scr2_pxl  = rand_pixel();
            scr3_pxl  = rand_pixel();
            obj_pxl   = 9'(rand_pixel());
            star0_pxl = 9'(rand_pixel());
            star1_pxl = 9'(rand_pixel());
            push_expected();
            pxl_cen = 1'b1;
            @(negedge clk);
            pxl_cen   = 1'b0;
            strobe_no = n + 1;
            want_rgb  = exp_rgb.pop_front();
            want_vis  = exp_vis.pop_front();
            check_rgb(rgb, want_rgb);
            check_blank({lvbl, lhbl}, want_vis);
            repeat (7) @(negedge clk);
        end

        if (errors == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "%0d checks failed", errors);
        end
    end

endmodule
